/* mcr3_input.f */
+incdir+include
logic/mcr3_input_pkg.sv
logic/rom_loader.sv
logic/reset_gen.sv
logic/game_config.sv
logic/player_merge.sv
logic/analog_select.sv
logic/cabinet_ports.sv
logic/mcr3_input_top.sv
verif/tb_mcr3_input.sv

/* Makefile */
# Verilator simulation of the MCR III input front end

VERILATOR ?= verilator
TOP       ?= tb_mcr3_input
FLIST     ?= mcr3_input.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* include/mcr3_input_vectors.svh */
// ====================
// Port table for the input front end testbench, included inside the
// testbench module. Rows are applied in order by the table loop
// ====================
`ifndef MCR3_INPUT_VECTORS_SVH
`define MCR3_INPUT_VECTORS_SVH

typedef struct packed {
	logic [7:0]                   game;
	mcr3_input_pkg::menu_opts_t   menu;
	logic                         steer_sel;
	logic                         coin;
	mcr3_input_pkg::player_ctrl_t joy1;
	mcr3_input_pkg::player_ctrl_t joy2;
	logic [15:0]                  stick1;
	logic [15:0]                  stick2;
	logic [8:0]                   spin1;
	logic [8:0]                   spin2;
	logic [7:0]                   pad1;
	logic [7:0]                   pad2;
	mcr3_input_pkg::cab_ports_t   exp;
} vec_t;

localparam int NUM_VECTORS = 11;

vec_t vectors [0:NUM_VECTORS-1];

// Columns: game, menu, steer_sel, coin, joy1, joy2, stick1, stick2,
// spin1, spin2, pad1, pad2, expected in0..in4
// The analog byte (in2 for spyhunt and turbo, in1 for crater) is 00
// here and is worked out by the testbench from the analog rules
task automatic fill_vectors;
	vectors[0]  = '{8'd0, 4'h0, 1'b1, 1'b1, 12'h010, 12'h000, 16'h0010, 16'h0000,
		9'h000, 9'h000, 8'h10, 8'h00, 40'hfe_ef_00_5a_ff};
	vectors[1]  = '{8'd0, 4'h0, 1'b0, 1'b0, 12'h300, 12'h080, 16'hc020, 16'h0000,
		9'h000, 9'h000, 8'h10, 8'h90, 40'hef_fa_00_5a_ff};
	vectors[2]  = '{8'd1, 4'h0, 1'b1, 1'b0, 12'h000, 12'h050, 16'h0000, 16'h00e0,
		9'h011, 9'h000, 8'h10, 8'h90, 40'hff_fa_00_5a_ff};
	// Analog gas, the shifter follows the stick Y sign
	vectors[3]  = '{8'd1, 4'h4, 1'b0, 1'b1, 12'h000, 12'h200, 16'h0000, 16'he020,
		9'h011, 9'h000, 8'h10, 8'h90, 40'hfe_ff_00_5a_ff};
	vectors[4]  = '{8'd1, 4'h2, 1'b1, 1'b0, 12'h000, 12'h200, 16'h0000, 16'he020,
		9'h011, 9'h000, 8'h10, 8'h40, 40'hef_ff_00_5a_ff};
	vectors[5]  = '{8'd2, 4'h0, 1'b0, 1'b1, 12'h118, 12'h024, 16'h0000, 16'he020,
		9'h011, 9'h0a5, 8'h10, 8'h40, 40'he6_00_b3_5a_ff};
	vectors[6]  = '{8'd2, 4'h0, 1'b0, 1'b0, 12'h240, 12'h000, 16'h0000, 16'he020,
		9'h1c3, 9'h0a5, 8'h10, 8'h40, 40'hfb_00_ef_5a_ff};
	vectors[7]  = '{8'd3, 4'h0, 1'b1, 1'b1, 12'h010, 12'h000, 16'h0000, 16'he020,
		9'h1c3, 9'h0a5, 8'h10, 8'h40, 40'hff_ff_ff_5a_ff};
	vectors[8]  = '{8'd0, 4'h2, 1'b1, 1'b0, 12'h020, 12'h000, 16'h0000, 16'h0000,
		9'h1c3, 9'h0a5, 8'hf0, 8'h40, 40'hff_fd_00_5a_ff};
	vectors[9]  = '{8'd1, 4'h4, 1'b0, 1'b0, 12'h020, 12'h000, 16'h3000, 16'h0000,
		9'h1c3, 9'h0a5, 8'hf0, 8'h40, 40'hef_fd_00_5a_ff};
	vectors[10] = '{8'd2, 4'h0, 1'b0, 1'b0, 12'h000, 12'h000, 16'h3000, 16'h0000,
		9'h1c3, 9'h0a5, 8'hf0, 8'h40, 40'hff_00_ff_5a_ff};
endtask

`endif

/* verif/tb_mcr3_input.sv */
// ====================
// Testbench for the MCR III input front end: ROM download, reset
// sequence, sound ROM, then the port table and a random spinner run
// ====================
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module tb_mcr3_input;

	`include "mcr3_input_vectors.svh"

	localparam int RAND_STEPS = 32;
	localparam int NUM_DL = 10;
	localparam int LIMIT = NUM_VECTORS * 20 + RAND_STEPS * 20 + NUM_DL * 4
		+ `MCR3_RESET_HOLD + 400;

	logic clk_sys = 1'b0;
	logic rst = 1'b1;
	mcr3_input_pkg::dl_bus_t      dl;
	logic                         rst_ext, btn_reset, steer_sel, coin;
	mcr3_input_pkg::menu_opts_t   menu;
	mcr3_input_pkg::player_ctrl_t joy_p1, joy_p2;
	logic [15:0]                  stick_p1, stick_p2;
	logic [8:0]                   spin_p1, spin_p2;
	logic [7:0]                   pad_p1, pad_p2;
	logic [`MCR3_SND_W-1:0]       snd_addr;
	mcr3_input_pkg::mem_wr_t      prog_wr, sprite_wr;
	logic                         bg_wr, game_reset, landscape, loading;
	logic [`MCR3_DL_ADDR_W-1:0]   bg_addr;
	logic [7:0]                   bg_data, snd_data;
	mcr3_input_pkg::cab_ports_t   ports;

	int         errors = 0;
	int         checks = 0;
	logic [31:0] rng = 32'h318957e8;
	logic [24:0] dl_addrs [0:NUM_DL-1] = '{25'h00100, 25'h00101, 25'h0e123, 25'h0e124,
		25'h10456, 25'h14001, 25'h18010, 25'h18011, 25'h28005, 25'h2a000};

	// Analog reference state
	logic       stick_from_p2, pad_from_p2, spin_from_p2;
	logic [7:0] last_pad1, last_pad2;
	logic [8:0] last_spin1, last_spin2;

	mcr3_input_top UUT (.*);

	always #2 clk_sys = ~clk_sys;

	// Watchdog
	initial begin
		repeat (LIMIT) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Download byte pattern, spread over the whole address
	function automatic logic [7:0] byte_for(input logic [24:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]} ^ 8'h3c;
	endfunction

	function automatic logic [7:0] steer_from_stick(input logic [7:0] x);
		logic signed [7:0] sx;
		sx = x;
		return 8'h70 + 8'(sx >>> 1);
	endfunction

	function automatic logic [7:0] steer_from_paddle(input logic [7:0] p);
		logic signed [7:0] sp;
		sp = p ^ 8'h80;
		return 8'h70 + 8'(sp >>> 1);
	endfunction

	function automatic logic [7:0] gas_from_stick(input logic [7:0] y, input logic is_turbo);
		logic [7:0] raw;
		if (y[7])
			raw = -y;
		else
			raw = is_turbo ? y : 8'h00;
		return (raw << 1) | 8'h01;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	// One download beat, outputs checked after the clock edge
	task automatic dl_beat(input logic [7:0] idx, input logic [24:0] a, input logic [7:0] d);
		logic        req_p, req_s;
		logic [24:0] r;
		logic [24:0] s;
		@(negedge clk_sys);
		req_p = prog_wr.req;
		req_s = sprite_wr.req;
		dl.wr = 1'b1;
		dl.index = idx;
		dl.addr = a;
		dl.data = d;
		@(negedge clk_sys);
		dl.wr = 1'b0;
		if (idx == 8'd0) begin
			r = (a < 25'h10000) ? a : ((a & ~25'h7fff) | ((a & 25'h3fff) << 1) | ((a >> 14) & 1));
			s = a - 25'h18000;
			check_val("prog_wr.req", prog_wr.req, !req_p);
			check_val("sprite_wr.req", sprite_wr.req, !req_s);
			check_val("prog_wr.addr", prog_wr.addr, r[23:1]);
			check_val("prog_wr.ds", prog_wr.ds, r[0] ? 2'b10 : 2'b01);
			check_val("prog_wr.data", prog_wr.data, {d, d});
			check_val("sprite_wr.addr", sprite_wr.addr, s[23:1]);
			check_val("sprite_wr.ds", sprite_wr.ds, s[0] ? 2'b10 : 2'b01);
			check_val("sprite_wr.data", sprite_wr.data, {d, d});
			check_val("bg_wr", bg_wr, 1'b1);
			check_val("bg_addr", bg_addr, 25'(a - 25'h28000));
			check_val("bg_data", bg_data, d);
			check_val("game_reset", game_reset, 1'b1);
			check_val("loading", loading, 1'b1);
		end
	endtask

	task automatic snd_check(input logic [13:0] sa, input logic [7:0] exp);
		@(negedge clk_sys);
		snd_addr = sa;
		@(negedge clk_sys);
		check_val("snd_data", snd_data, exp);
	endtask

	// Reset sequence after the download ends
	task automatic check_reset_pulse;
		int n;
		n = 0;
		while (game_reset && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (game_reset) begin
			errors++;
			$display("game_reset never released after the download");
		end else begin
			n = 0;
			while (!game_reset && n < `MCR3_RESET_HOLD + 10) begin
				@(negedge clk_sys);
				n++;
			end
			if (!game_reset || n < `MCR3_RESET_HOLD - 2 || n > `MCR3_RESET_HOLD + 2) begin
				errors++;
				$display("second reset pulse missing or mistimed after %0d cycles", n);
			end
			@(negedge clk_sys);
			check_val("game_reset", game_reset, 1'b0);
			repeat (20) begin
				@(negedge clk_sys);
				check_val("game_reset", game_reset, 1'b0);
			end
		end
	endtask

	task automatic apply_row(input int i, output mcr3_input_pkg::cab_ports_t exp);
		vec_t v;
		logic [15:0] st;
		logic [7:0] pd;
		v = vectors[i];
		dl_beat(8'd1, 25'd0, v.game);
		@(negedge clk_sys);
		menu = v.menu;
		steer_sel = v.steer_sel;
		coin = v.coin;
		joy_p1 = v.joy1;
		joy_p2 = v.joy2;
		stick_p1 = v.stick1;
		stick_p2 = v.stick2;
		spin_p1 = v.spin1;
		spin_p2 = v.spin2;
		pad_p1 = v.pad1;
		pad_p2 = v.pad2;
		// Last active player and last moved controls, player 2 wins a tie of moves
		if (v.joy1 != '0)
			stick_from_p2 = 1'b0;
		else if (v.joy2 != '0)
			stick_from_p2 = 1'b1;
		if (v.pad1 != last_pad1)
			pad_from_p2 = 1'b0;
		if (v.pad2 != last_pad2)
			pad_from_p2 = 1'b1;
		if (v.spin1 != last_spin1)
			spin_from_p2 = 1'b0;
		if (v.spin2 != last_spin2)
			spin_from_p2 = 1'b1;
		last_pad1 = v.pad1;
		last_pad2 = v.pad2;
		last_spin1 = v.spin1;
		last_spin2 = v.spin2;
		st = stick_from_p2 ? v.stick2 : v.stick1;
		pd = pad_from_p2 ? v.pad2 : v.pad1;
		exp = v.exp;
		if (v.game == 8'd0 || v.game == 8'd1) begin
			if (!v.steer_sel)
				exp.in2 = gas_from_stick(st[15:8], v.game == 8'd1);
			else if (v.menu.steer_paddle)
				exp.in2 = steer_from_paddle(pd);
			else
				exp.in2 = steer_from_stick(st[7:0]);
		end else if (v.game == 8'd2) begin
			exp.in1 = spin_from_p2 ? v.spin2[7:0] : v.spin1[7:0];
		end
		repeat (6) @(negedge clk_sys);
	endtask

	initial begin
		mcr3_input_pkg::cab_ports_t exp;
		logic [8:0] nv;
		dl = '0;
		dl.index = 8'hff;
		rst_ext = 1'b0;
		btn_reset = 1'b0;
		menu = '0;
		steer_sel = 1'b0;
		coin = 1'b0;
		joy_p1 = '0;
		joy_p2 = '0;
		stick_p1 = '0;
		stick_p2 = '0;
		spin_p1 = '0;
		spin_p2 = '0;
		pad_p1 = '0;
		pad_p2 = '0;
		snd_addr = '0;
		stick_from_p2 = 1'b0;
		pad_from_p2 = 1'b0;
		spin_from_p2 = 1'b0;
		last_pad1 = '0;
		last_pad2 = '0;
		last_spin1 = '0;
		last_spin2 = '0;
		fill_vectors();
		repeat (8) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		check_val("ports", ports, 40'hff_ff_ff_ff_ff);
		check_val("game_reset", game_reset, 1'b1);
		check_val("loading", loading, 1'b0);
		check_val("prog_wr.req", prog_wr.req, 1'b0);
		check_val("sprite_wr.req", sprite_wr.req, 1'b0);
		check_val("bg_wr", bg_wr, 1'b0);

		// ROM download, then the delayed second reset
		for (int i = 0; i < NUM_DL; i++)
			dl_beat(8'd0, dl_addrs[i], byte_for(dl_addrs[i]));
		@(negedge clk_sys);
		dl.index = 8'hff;
		check_reset_pulse();

		snd_check(14'h2123, byte_for(25'h0e123));
		snd_check(14'h2124, byte_for(25'h0e124));
		snd_check(14'h0456, byte_for(25'h10456));

		// DIP bank, service off
		dl_beat(8'd254, 25'd0, 8'h5a);
		dl_beat(8'd254, 25'd1, 8'hfe);

		// ====================
		// Port table
		// ====================
		for (int i = 0; i < NUM_VECTORS; i++) begin
			apply_row(i, exp);
			check_val($sformatf("row %0d ports.in0", i), ports.in0, exp.in0);
			check_val($sformatf("row %0d ports.in1", i), ports.in1, exp.in1);
			check_val($sformatf("row %0d ports.in2", i), ports.in2, exp.in2);
			check_val($sformatf("row %0d ports.in3", i), ports.in3, exp.in3);
			check_val($sformatf("row %0d ports.in4", i), ports.in4, exp.in4);
			check_val($sformatf("row %0d landscape", i), landscape, vectors[i].game == 8'd2);
		end

		// Random spinner moves, crater game still selected
		for (int k = 0; k < RAND_STEPS; k++) begin
			rng = xorshift(rng);
			@(negedge clk_sys);
			if (rng[0]) begin
				nv = rng[17:9];
				if (nv == spin_p2)
					nv = nv ^ 9'h001;
				spin_p2 = nv;
			end else begin
				nv = rng[17:9];
				if (nv == spin_p1)
					nv = nv ^ 9'h001;
				spin_p1 = nv;
			end
			repeat (6) @(negedge clk_sys);
			check_val("ports.in1", ports.in1, nv[7:0]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* logic/mcr3_input_top.sv */
// ====================
// MCR III scrolling board input and loader front end
// ====================
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module mcr3_input_top (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  mcr3_input_pkg::dl_bus_t      dl,
	input  logic                         rst_ext,
	input  logic                         btn_reset,
	input  mcr3_input_pkg::menu_opts_t   menu,
	input  mcr3_input_pkg::player_ctrl_t joy_p1,
	input  mcr3_input_pkg::player_ctrl_t joy_p2,
	input  logic [15:0]                  stick_p1,
	input  logic [15:0]                  stick_p2,
	input  logic [8:0]                   spin_p1,
	input  logic [8:0]                   spin_p2,
	input  logic [7:0]                   pad_p1,
	input  logic [7:0]                   pad_p2,
	input  logic                         steer_sel,
	input  logic                         coin,
	input  logic [`MCR3_SND_W-1:0]       snd_addr,
	output mcr3_input_pkg::mem_wr_t      prog_wr,
	output mcr3_input_pkg::mem_wr_t      sprite_wr,
	output logic                         bg_wr,
	output logic [`MCR3_DL_ADDR_W-1:0]   bg_addr,
	output logic [`MCR3_BYTE_W-1:0]      bg_data,
	output logic [`MCR3_BYTE_W-1:0]      snd_data,
	output logic                         game_reset,
	output mcr3_input_pkg::cab_ports_t   ports,
	output logic                         landscape,
	output logic                         loading
);

	logic                         load_done;
	mcr3_input_pkg::game_t        game;
	logic [`MCR3_BYTE_W-1:0]      dip0;
	logic                         service;
	mcr3_input_pkg::player_ctrl_t ctrl;
	logic [15:0]                  stick;
	logic [7:0]                   steer_x, steer_pad, gas;
	logic [8:0]                   spin;

	// ====================
	// Loader and reset
	// ====================
	rom_loader u_rom_loader (
		.clk_sys(clk_sys), .rst(rst), .dl(dl), .snd_addr(snd_addr),
		.prog_wr(prog_wr), .sprite_wr(sprite_wr), .bg_wr(bg_wr),
		.bg_addr(bg_addr), .bg_data(bg_data), .snd_data(snd_data),
		.loading(loading), .load_done(load_done)
	);

	reset_gen u_reset_gen (
		.clk_sys(clk_sys), .rst(rst), .rst_ext(rst_ext), .btn_reset(btn_reset),
		.menu(menu), .load_done(load_done), .game_reset(game_reset)
	);

	game_config u_game_config (
		.clk_sys(clk_sys), .rst(rst), .dl(dl), .game(game), .dip0(dip0),
		.service(service)
	);

	// ====================
	// Controls
	// ====================
	player_merge u_player_merge (
		.clk_sys(clk_sys), .rst(rst), .joy_p1(joy_p1), .joy_p2(joy_p2),
		.stick_p1(stick_p1), .stick_p2(stick_p2), .ctrl(ctrl), .stick(stick)
	);

	analog_select u_analog_select (
		.clk_sys(clk_sys), .rst(rst), .spin_p1(spin_p1), .spin_p2(spin_p2),
		.pad_p1(pad_p1), .pad_p2(pad_p2), .stick(stick), .game(game),
		.steer_x(steer_x), .steer_pad(steer_pad), .gas(gas), .spin(spin)
	);

	// Analog gas drives the Turbo shifter from the stick direction
	cabinet_ports u_cabinet_ports (
		.clk_sys(clk_sys), .rst(rst), .game(game), .ctrl(ctrl), .dip0(dip0),
		.service(service), .menu(menu), .steer_sel(steer_sel),
		.steer_x(steer_x), .steer_pad(steer_pad), .gas(gas), .spin(spin),
		.shift_alt(~stick[15]), .coin(coin), .ports(ports),
		.landscape(landscape)
	);

endmodule

/* logic/cabinet_ports.sv */
// ====================
// Builds the five cabinet input bytes for the selected game
// ====================
`timescale 1ns/1ps

module cabinet_ports (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  mcr3_input_pkg::game_t        game,
	input  mcr3_input_pkg::player_ctrl_t ctrl,
	input  logic [7:0]                   dip0,
	input  logic                         service,
	input  mcr3_input_pkg::menu_opts_t   menu,
	input  logic                         steer_sel,
	input  logic [7:0]                   steer_x,
	input  logic [7:0]                   steer_pad,
	input  logic [7:0]                   gas,
	input  logic [8:0]                   spin,
	input  logic                         shift_alt,
	input  logic                         coin,
	output mcr3_input_pkg::cab_ports_t   ports,
	output logic                         landscape
);

	mcr3_input_pkg::cab_ports_t next_ports;
	logic                       next_land;
	logic [7:0]                 drive;
	logic                       turbo_shift;

	// Output port bit 7 picks steering or gas on the same input
	assign drive = steer_sel ? (menu.steer_paddle ? steer_pad : steer_x) : gas;
	assign turbo_shift = menu.gas_analog ? shift_alt : ctrl.shift;

	always_comb begin
		next_land      = 1'b0;
		next_ports.in0 = 8'hff;
		next_ports.in1 = 8'hff;
		next_ports.in2 = 8'hff;
		next_ports.in3 = dip0;
		next_ports.in4 = 8'hff;
		case (game)
			mcr3_input_pkg::spyhunt: begin
				next_ports.in0 = ~{service, 2'b00, ctrl.shift, 3'b000, coin};
				next_ports.in1 = ~{3'b000, ctrl.fire_a, ctrl.fire_c, ctrl.fire_e,
					ctrl.fire_b, ctrl.fire_d};
				next_ports.in2 = drive;
			end
			mcr3_input_pkg::turbo: begin
				next_ports.in0 = ~{service, 2'b00, turbo_shift, 3'b000, coin};
				next_ports.in1 = ~{3'b000, ctrl.fire_e, ctrl.fire_d, ctrl.fire_c,
					ctrl.fire_b, ctrl.fire_a};
				next_ports.in2 = drive;
			end
			mcr3_input_pkg::crater: begin
				next_land      = 1'b1;
				next_ports.in0 = ~{service, 2'b00, ctrl.fire_a, ctrl.fire_e, ctrl.shift,
					1'b0, coin};
				// dial position straight from the spinner count
				next_ports.in1 = spin[7:0];
				next_ports.in2 = ~{1'b0, ctrl.fire_b, 1'b0, ctrl.fire_c, ctrl.down,
					ctrl.up, 2'b00};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ports     <= '1;
			landscape <= 1'b0;
		end else begin
			ports     <= next_ports;
			landscape <= next_land;
		end
	end

endmodule

/* logic/analog_select.sv */
// ====================
// Picks the last moved spinner and paddle, forms steering and gas
// ====================
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module analog_select (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic [8:0]            spin_p1,
	input  logic [8:0]            spin_p2,
	input  logic [7:0]            pad_p1,
	input  logic [7:0]            pad_p2,
	input  logic [15:0]           stick,
	input  mcr3_input_pkg::game_t game,
	output logic [7:0]            steer_x,
	output logic [7:0]            steer_pad,
	output logic [7:0]            gas,
	output logic [8:0]            spin
);

	logic [8:0] old_sp1, old_sp2;
	logic [7:0] old_pd1, old_pd2;
	logic       sp_sel, pd_sel;
	logic [7:0] pad;
	logic [7:0] stick_y;
	logic [7:0] gas_raw;

	// Previous samples for change detection
	always_ff @(posedge clk_sys) begin
		old_sp1 <= spin_p1;
		old_sp2 <= spin_p2;
		old_pd1 <= pad_p1;
		old_pd2 <= pad_p2;
		spin    <= sp_sel ? spin_p2 : spin_p1;
		pad     <= pd_sel ? pad_p2 : pad_p1;
	end

	// Player 2 takes a simultaneous change
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sp_sel <= 1'b0;
			pd_sel <= 1'b0;
		end else begin
			if (old_sp1 != spin_p1)
				sp_sel <= 1'b0;
			if (old_sp2 != spin_p2)
				sp_sel <= 1'b1;
			if (old_pd1 != pad_p1)
				pd_sel <= 1'b0;
			if (old_pd2 != pad_p2)
				pd_sel <= 1'b1;
		end
	end

	// ====================
	// Steering and gas
	// ====================
	assign steer_x   = `MCR3_STEER_CENTER + {stick[7], stick[7:1]};
	assign steer_pad = `MCR3_STEER_CENTER + {~pad[7], ~pad[7], pad[6:1]};

	assign stick_y = stick[15:8];

	// Pushing up is negative Y, only Turbo also takes pull-back
	always_comb begin
		if (stick_y[7])
			gas_raw = 8'h00 - stick_y;
		else if (game == mcr3_input_pkg::turbo)
			gas_raw = stick_y;
		else
			gas_raw = 8'h00;
	end

	assign gas = {gas_raw[6:0], 1'b1};

endmodule

/* logic/player_merge.sv */
// ====================
// Merges both players' buttons and follows the last active player
// ====================
`timescale 1ns/1ps

module player_merge (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  mcr3_input_pkg::player_ctrl_t joy_p1,
	input  mcr3_input_pkg::player_ctrl_t joy_p2,
	input  logic [15:0]                  stick_p1,
	input  logic [15:0]                  stick_p2,
	output mcr3_input_pkg::player_ctrl_t ctrl,
	output logic [15:0]                  stick
);

	logic sel_p2;
	logic sel_p2_next;

	// Player 1 wins when both press at once
	always_comb begin
		sel_p2_next = sel_p2;
		if (joy_p1 != '0)
			sel_p2_next = 1'b0;
		else if (joy_p2 != '0)
			sel_p2_next = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ctrl   <= '0;
			sel_p2 <= 1'b0;
		end else begin
			ctrl   <= joy_p1 | joy_p2;
			sel_p2 <= sel_p2_next;
		end
	end

	always_ff @(posedge clk_sys)
		stick <= sel_p2_next ? stick_p2 : stick_p1;

endmodule

/* logic/game_config.sv */
// ====================
// Game select and DIP bank captured from the download stream
// ====================
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module game_config (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  mcr3_input_pkg::dl_bus_t dl,
	output mcr3_input_pkg::game_t   game,
	output logic [`MCR3_BYTE_W-1:0] dip0,
	output logic                    service
);

	logic [`MCR3_BYTE_W-1:0] mode;
	logic [`MCR3_BYTE_W-1:0] dip [0:7];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mode <= 8'hff;
			game <= mcr3_input_pkg::none;
		end else begin
			if (dl.wr && dl.index == `MCR3_IDX_MOD)
				mode <= dl.data;
			case (mode)
				8'd0:    game <= mcr3_input_pkg::spyhunt;
				8'd1:    game <= mcr3_input_pkg::turbo;
				8'd2:    game <= mcr3_input_pkg::crater;
				default: game <= mcr3_input_pkg::none;
			endcase
		end
	end

	// Eight switch bytes at the start of the DIP index
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				dip[i] <= 8'hff;
		end else if (dl.wr && dl.index == `MCR3_IDX_DIP && dl.addr[24:3] == '0) begin
			dip[dl.addr[2:0]] <= dl.data;
		end
	end

	assign dip0    = dip[0];
	assign service = dip[1][0];

endmodule

/* logic/reset_gen.sv */
// ====================
// Game reset: held until a ROM is loaded, then a second short pulse
// ====================
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module reset_gen (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       rst_ext,
	input  logic                       btn_reset,
	input  mcr3_input_pkg::menu_opts_t menu,
	input  logic                       load_done,
	output logic                       game_reset
);

	localparam int cnt_w = $clog2(`MCR3_RESET_HOLD + 1);

	logic             rom_loaded;
	logic             hold;
	logic [cnt_w-1:0] count;

	// Any source that keeps the game parked
	assign hold = rst_ext | btn_reset | menu.soft_reset | ~rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_loaded <= 1'b0;
			count      <= cnt_w'(`MCR3_RESET_HOLD);
			game_reset <= 1'b1;
		end else begin
			if (load_done)
				rom_loaded <= 1'b1;
			if (hold)
				count <= cnt_w'(`MCR3_RESET_HOLD);
			else if (count != '0)
				count <= count - 1'b1;
			// extra pulse as the count passes one
			game_reset <= hold | (count == cnt_w'(1));
		end
	end

	a_reset_until_load: assert property (@(posedge clk_sys) disable iff (rst)
		!rom_loaded |-> game_reset)
		else $error("game released before a rom load");

endmodule

/* logic/rom_loader.sv */
// ====================
// Steers ROM download bytes to the program, sprite, sound and
// background targets and flags when a download finishes
// ====================
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module rom_loader (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  mcr3_input_pkg::dl_bus_t      dl,
	input  logic [`MCR3_SND_W-1:0]       snd_addr,
	output mcr3_input_pkg::mem_wr_t      prog_wr,
	output mcr3_input_pkg::mem_wr_t      sprite_wr,
	output logic                         bg_wr,
	output logic [`MCR3_DL_ADDR_W-1:0]   bg_addr,
	output logic [`MCR3_BYTE_W-1:0]      bg_data,
	output logic [`MCR3_BYTE_W-1:0]      snd_data,
	output logic                         loading,
	output logic                         load_done
);

	logic                        rom_sel;
	logic                        rom_wr;
	logic                        snd_wr;
	logic [`MCR3_DL_ADDR_W-1:0]  route_addr;
	logic [`MCR3_DL_ADDR_W-1:0]  sp_addr;
	logic                        loading_d;
	logic [`MCR3_BYTE_W-1:0]     snd_rom [0:(1 << `MCR3_SND_W)-1];

	assign rom_sel = (dl.index == `MCR3_IDX_ROM);
	assign rom_wr  = dl.wr & rom_sel;

	// CSD ROM area is 16 bit wide, bit 14 becomes the byte lane
	assign route_addr = (dl.addr < 25'h10000) ? dl.addr :
		{dl.addr[24:15], dl.addr[13:0], dl.addr[14]};
	assign sp_addr = dl.addr - `MCR3_SPRITE_BASE;

	// Sound ROM banks 7 and 8 of the 8K image
	assign snd_wr = rom_wr & ((dl.addr[24:13] == 12'd7) | (dl.addr[24:13] == 12'd8));

	// ====================
	// External port writes
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			prog_wr.req   <= 1'b0;
			sprite_wr.req <= 1'b0;
			bg_wr         <= 1'b0;
		end else begin
			bg_wr <= rom_wr;
			if (rom_wr) begin
				prog_wr.req    <= ~prog_wr.req;
				prog_wr.addr   <= route_addr[23:1];
				prog_wr.ds     <= {route_addr[0], ~route_addr[0]};
				prog_wr.data   <= {dl.data, dl.data};
				sprite_wr.req  <= ~sprite_wr.req;
				sprite_wr.addr <= sp_addr[23:1];
				sprite_wr.ds   <= {sp_addr[0], ~sp_addr[0]};
				sprite_wr.data <= {dl.data, dl.data};
			end
		end
	end

	// Background tiles are written at an offset
	always_ff @(posedge clk_sys) begin
		bg_addr <= dl.addr - `MCR3_BG_BASE;
		bg_data <= dl.data;
	end

	// ====================
	// Sound ROM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (snd_wr)
			snd_rom[dl.addr[`MCR3_SND_W-1:0]] <= dl.data;
		snd_data <= snd_rom[snd_addr];
	end

	// Download state and end of load
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			loading   <= 1'b0;
			loading_d <= 1'b0;
		end else begin
			loading   <= rom_sel;
			loading_d <= loading;
		end
	end

	assign load_done = loading_d & ~loading;

	// Request toggles only move on an accepted ROM byte
	a_req_only_on_wr: assert property (@(posedge clk_sys) disable iff (rst)
		!$past(rom_wr) |-> ($stable(prog_wr.req) && $stable(sprite_wr.req)))
		else $error("request toggle moved without a rom write");

endmodule

/* logic/mcr3_input_pkg.sv */
// ====================
// Types shared by the input front end and its testbench
// ====================
`include "mcr3_input_params.svh"

package mcr3_input_pkg;

	// One beat of the host download stream
	typedef struct packed {
		logic                        wr;
		logic [`MCR3_BYTE_W-1:0]     index;
		logic [`MCR3_DL_ADDR_W-1:0]  addr;
		logic [`MCR3_BYTE_W-1:0]     data;
	} dl_bus_t;

	// One player's buttons, MSB first as the host packs them
	typedef struct packed {
		logic spin_cw;
		logic spin_ccw;
		logic shift;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_ctrl_t;

	// OSD menu selections
	typedef struct packed {
		logic soft_reset;
		logic gas_analog;
		logic steer_paddle;
		logic steer_stick;
	} menu_opts_t;

	typedef enum logic [1:0] {
		spyhunt = 2'd0,
		turbo   = 2'd1,
		crater  = 2'd2,
		none    = 2'd3
	} game_t;

	// Cabinet input bytes as the game CPU reads them
	typedef struct packed {
		logic [7:0] in0;
		logic [7:0] in1;
		logic [7:0] in2;
		logic [7:0] in3;
		logic [7:0] in4;
	} cab_ports_t;

	// Write toward an external 16-bit ROM port, req toggles per byte
	typedef struct packed {
		logic        req;
		logic [22:0] addr;
		logic [1:0]  ds;
		logic [15:0] data;
	} mem_wr_t;

endpackage

/* include/mcr3_input_params.svh */
// ====================
// Widths, download indices, region bases and reset timing shared by
// the MCR III input front end. Include wherever one of these is used
// ====================
`ifndef MCR3_INPUT_PARAMS_SVH
`define MCR3_INPUT_PARAMS_SVH

// Bus widths
`define MCR3_BYTE_W 8
`define MCR3_DL_ADDR_W 25
`define MCR3_SND_W 14

// Download stream indices
`define MCR3_IDX_ROM 8'd0
`define MCR3_IDX_MOD 8'd1
`define MCR3_IDX_DIP 8'd254

// ROM image layout
`define MCR3_SPRITE_BASE 25'h18000
`define MCR3_BG_BASE 25'h28000

// Second reset pulse delay in clk_sys cycles
`define MCR3_RESET_HOLD 64

// Analog steering zero point
`define MCR3_STEER_CENTER 8'h70

`endif
